/* verilog/fe_arch_pkg.sv */
package fe_arch_pkg;

    localparam int ARCH_WIDTH = 32;
    localparam int INST_WIDTH = 32;
    localparam int REG_IDX_WIDTH = 5;

    // pc, fetch address and register operand
    typedef logic [ARCH_WIDTH-1:0] arch_width_t;
    typedef logic [INST_WIDTH-1:0] inst_t;
    typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;
    typedef logic [6:0] opcode_t;

    // first fetch address after reset
    localparam arch_width_t RESET_PC = 32'h4000_0000;

    // rv32i opcodes that can change the program flow
    localparam opcode_t OPC_BRANCH = 7'b110_0011;
    localparam opcode_t OPC_JAL = 7'b110_1111;
    localparam opcode_t OPC_JALR = 7'b110_0111;

endpackage

/* verilog/fe_ctrl_pkg.sv */
package fe_ctrl_pkg;

    // source of the next pc value
    typedef enum logic [1:0] {
        PC_SEL_PC,
        PC_SEL_INC4,
        PC_SEL_ALU,
        PC_SEL_RST
    } pc_sel_t;

    // branch outcome in execute
    typedef enum logic {
        B_NT,
        B_T
    } branch_t;

    // effect of a fetched word on the program flow
    typedef enum logic [1:0] {
        CLS_SEQ,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR
    } inst_class_t;

endpackage

/* verilog/fe_decode.sv */
module fe_decode
    import fe_arch_pkg::*, fe_ctrl_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic rsp_accept,
    input  logic bubble_dec,
    input  logic hold,
    input  inst_t imem_rsp_inst,
    input  arch_width_t fetch_pc,
    output logic dec_valid,
    output logic branch_in_dec,
    output logic jump_in_dec,
    output arch_width_t pc_dec,
    output inst_t dec_inst,
    output inst_class_t dec_class,
    output arch_width_t dec_imm,
    output pc_sel_t dec_pc_sel
);

opcode_t opcode;
logic load;

// a bubble wins over a response, the back end freezes both
assign load = !hold && !bubble_dec && rsp_accept;

always_ff @(posedge clk) begin
    if (rst) begin
        dec_valid <= 1'b0;
    end else if (!hold) begin
        if (bubble_dec) begin
            dec_valid <= 1'b0;
        end else if (rsp_accept) begin
            dec_valid <= 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (load) begin
        dec_inst <= imem_rsp_inst;
        pc_dec <= fetch_pc;
    end
end

assign opcode = dec_inst[6:0];

always_comb begin
    case (opcode)
        OPC_BRANCH: dec_class = CLS_BRANCH;
        OPC_JAL: dec_class = CLS_JAL;
        OPC_JALR: dec_class = CLS_JALR;
        default: dec_class = CLS_SEQ;
    endcase
end

// only flow changes need an immediate, i-type covers jalr
always_comb begin
    case (dec_class)
        CLS_BRANCH: dec_imm = {{20{dec_inst[31]}}, dec_inst[7], dec_inst[30:25],
                               dec_inst[11:8], 1'b0};
        CLS_JAL: dec_imm = {{12{dec_inst[31]}}, dec_inst[19:12], dec_inst[20],
                            dec_inst[30:21], 1'b0};
        default: dec_imm = {{21{dec_inst[31]}}, dec_inst[30:20]};
    endcase
end

assign branch_in_dec = dec_valid && (dec_class == CLS_BRANCH);
assign jump_in_dec = dec_valid && ((dec_class == CLS_JAL) || (dec_class == CLS_JALR));

// flow changes keep the pc until execute resolves them
assign dec_pc_sel = (dec_class == CLS_SEQ) ? PC_SEL_INC4 : PC_SEL_PC;

endmodule

/* verilog/fe_ctrl.sv */
module fe_ctrl
    import fe_arch_pkg::*, fe_ctrl_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic imem_req_ready,
    input  logic imem_rsp_valid,
    input  logic be_stall,
    input  logic branch_in_dec,
    input  logic jump_in_dec,
    input  logic dec_valid,
    input  logic exe_valid,
    input  logic flow_in_exe,
    input  arch_width_t pc_dec,
    input  arch_width_t pc_exe,
    input  pc_sel_t dec_pc_sel,
    output logic imem_req_valid,
    output logic imem_rsp_ready,
    output logic pc_we,
    output logic bubble_dec,
    output logic exe_advance,
    output pc_sel_t pc_sel
);

typedef enum logic [2:0] {
    RST,
    STEADY,
    STALL_FLOW,
    STALL_FE_IC,
    STALL_BE
} stall_state_t;

stall_state_t state, nx_state;
logic flow_act;
logic ic_act;
logic flow_match;
logic flow_res;
logic flow_res_d;
logic save_entry;
logic clear_entry;
logic entry_valid;
arch_width_t entry_pc;
logic req_pending;
pc_sel_t redirect_sel;

assign flow_act = branch_in_dec || jump_in_dec;
// nothing fetched is waiting in decode
assign ic_act = !dec_valid;

// the stalling instruction has reached execute
assign flow_match = entry_valid && exe_valid && (pc_exe == entry_pc);
assign flow_res = flow_match && !be_stall;
assign redirect_sel = flow_in_exe ? PC_SEL_ALU : PC_SEL_INC4;

always_ff @(posedge clk) begin
    if (rst) begin
        state <= RST;
        flow_res_d <= 1'b0;
        req_pending <= 1'b0;
    end else begin
        state <= nx_state;
        flow_res_d <= flow_res;
        if (imem_req_valid && imem_req_ready) begin
            req_pending <= 1'b1;
        end else if (imem_rsp_valid && imem_rsp_ready) begin
            req_pending <= 1'b0;
        end
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        entry_valid <= 1'b0;
    end else if (save_entry) begin
        entry_valid <= 1'b1;
    end else if (clear_entry) begin
        entry_valid <= 1'b0;
    end
end

always_ff @(posedge clk) begin
    if (save_entry) begin
        entry_pc <= pc_dec;
    end
end

// back end first, then flow change, then instruction memory
always_comb begin
    nx_state = state;
    save_entry = 1'b0;
    clear_entry = 1'b0;
    case (state)
        RST: begin
            if (imem_req_ready) begin
                nx_state = STALL_FE_IC;
            end
        end
        STEADY: begin
            if (be_stall) begin
                nx_state = STALL_BE;
            end else if (flow_act) begin
                save_entry = 1'b1;
                nx_state = STALL_FLOW;
            end else begin
                nx_state = STALL_FE_IC;
            end
        end
        STALL_FLOW: begin
            if (flow_res) begin
                clear_entry = 1'b1;
                nx_state = STALL_FE_IC;
            end else if (be_stall) begin
                nx_state = STALL_BE;
            end
        end
        STALL_FE_IC: begin
            if (imem_rsp_valid && imem_rsp_ready) begin
                nx_state = STEADY;
            end
        end
        STALL_BE: begin
            if (!be_stall) begin
                if (entry_valid) begin
                    // redirect only on the first cycle of the resolution
                    if (flow_res && !flow_res_d) begin
                        clear_entry = 1'b1;
                        nx_state = STALL_FE_IC;
                    end else begin
                        nx_state = STALL_FLOW;
                    end
                end else if (flow_act) begin
                    save_entry = 1'b1;
                    nx_state = STALL_FLOW;
                end else begin
                    nx_state = STALL_FE_IC;
                end
            end
        end
        default: nx_state = RST;
    endcase
end

// execute moves every cycle unless the back end holds it
assign exe_advance = (state != RST) && !be_stall;

always_comb begin
    imem_req_valid = 1'b0;
    imem_rsp_ready = 1'b0;
    pc_we = 1'b0;
    pc_sel = PC_SEL_PC;
    bubble_dec = 1'b1;
    case (state)
        RST: begin
            pc_sel = PC_SEL_RST;
        end
        STEADY: begin
            pc_sel = dec_pc_sel;
            pc_we = !be_stall && !flow_act && !ic_act;
        end
        STALL_FLOW: begin
            if (flow_res) begin
                pc_sel = redirect_sel;
                pc_we = 1'b1;
            end
        end
        STALL_FE_IC: begin
            // single outstanding request
            imem_req_valid = !req_pending && !be_stall;
            imem_rsp_ready = !be_stall;
            bubble_dec = !imem_rsp_valid;
        end
        STALL_BE: begin
            if (!be_stall) begin
                if (entry_valid) begin
                    if (flow_res && !flow_res_d) begin
                        pc_sel = redirect_sel;
                        pc_we = 1'b1;
                    end
                end else if (!flow_act && !ic_act) begin
                    pc_sel = PC_SEL_INC4;
                    pc_we = 1'b1;
                end
            end
        end
        default: pc_sel = PC_SEL_PC;
    endcase
end

endmodule

/* verilog/fe_execute.sv */
module fe_execute
    import fe_arch_pkg::*, fe_ctrl_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic exe_advance,
    input  logic dec_valid,
    input  arch_width_t pc_dec,
    input  arch_width_t dec_imm,
    input  arch_width_t rs1_data,
    input  arch_width_t rs2_data,
    input  inst_t dec_inst,
    input  inst_class_t dec_class,
    output logic exe_valid,
    output logic flow_in_exe,
    output arch_width_t pc_exe,
    output arch_width_t exe_target,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx
);

inst_t exe_inst;
inst_class_t exe_class;
arch_width_t exe_imm;
branch_t br_res;
logic [2:0] funct3;

// an empty decode leaves a bubble behind
always_ff @(posedge clk) begin
    if (rst) begin
        exe_valid <= 1'b0;
    end else if (exe_advance) begin
        exe_valid <= dec_valid;
    end
end

always_ff @(posedge clk) begin
    if (exe_advance) begin
        pc_exe <= pc_dec;
        exe_inst <= dec_inst;
        exe_class <= dec_class;
        exe_imm <= dec_imm;
    end
end

assign rs1_idx = exe_inst[19:15];
assign rs2_idx = exe_inst[24:20];
assign funct3 = exe_inst[14:12];

always_comb begin
    case (funct3)
        3'b000: br_res = (rs1_data == rs2_data) ? B_T : B_NT;
        3'b001: br_res = (rs1_data != rs2_data) ? B_T : B_NT;
        3'b100: br_res = ($signed(rs1_data) < $signed(rs2_data)) ? B_T : B_NT;
        3'b101: br_res = ($signed(rs1_data) >= $signed(rs2_data)) ? B_T : B_NT;
        3'b110: br_res = (rs1_data < rs2_data) ? B_T : B_NT;
        3'b111: br_res = (rs1_data >= rs2_data) ? B_T : B_NT;
        default: br_res = B_NT;
    endcase
end

assign flow_in_exe = exe_valid &&
    (((exe_class == CLS_BRANCH) && (br_res == B_T)) ||
     (exe_class == CLS_JAL) || (exe_class == CLS_JALR));

// jalr is register relative with bit 0 dropped
always_comb begin
    if (exe_class == CLS_JALR) begin
        exe_target = rs1_data + exe_imm;
        exe_target[0] = 1'b0;
    end else begin
        exe_target = pc_exe + exe_imm;
    end
end

endmodule

/* verilog/fe_result.sv */
module fe_result
    import fe_arch_pkg::*, fe_ctrl_pkg::*;
#(
    parameter arch_width_t reset_pc = RESET_PC
) (
    input  logic clk,
    input  logic rst,
    input  logic pc_we,
    input  logic exe_valid,
    input  logic exe_advance,
    input  logic flow_in_exe,
    input  pc_sel_t pc_sel,
    input  arch_width_t exe_target,
    input  arch_width_t pc_exe,
    output arch_width_t imem_addr,
    output arch_width_t fetch_pc,
    output logic commit_valid,
    output arch_width_t commit_pc,
    output arch_width_t commit_next_pc
);

arch_width_t pc;
arch_width_t pc_next;
logic retire;

always_comb begin
    case (pc_sel)
        PC_SEL_PC: pc_next = pc;
        PC_SEL_INC4: pc_next = pc + arch_width_t'(4);
        PC_SEL_ALU: pc_next = exe_target;
        PC_SEL_RST: pc_next = reset_pc;
        default: pc_next = pc;
    endcase
end

always_ff @(posedge clk) begin
    if (rst) begin
        pc <= reset_pc;
    end else if (pc_we) begin
        pc <= pc_next;
    end
end

// pc only moves once the word is back, so it tags the outstanding request
assign imem_addr = pc;
assign fetch_pc = pc;

// instruction retires as it leaves execute
assign retire = exe_valid && exe_advance;

always_ff @(posedge clk) begin
    if (rst) begin
        commit_valid <= 1'b0;
    end else begin
        commit_valid <= retire;
    end
end

always_ff @(posedge clk) begin
    if (retire) begin
        commit_pc <= pc_exe;
        commit_next_pc <= flow_in_exe ? exe_target : pc_exe + arch_width_t'(4);
    end
end

endmodule

/* verilog/fe_top.sv */
module fe_top
    import fe_arch_pkg::*, fe_ctrl_pkg::*;
#(
    parameter arch_width_t reset_pc = RESET_PC
) (
    input  logic clk,
    input  logic rst,
    input  logic imem_req_ready,
    input  logic imem_rsp_valid,
    input  logic be_stall,
    input  inst_t imem_rsp_inst,
    input  arch_width_t rs1_data,
    input  arch_width_t rs2_data,
    output logic imem_req_valid,
    output logic imem_rsp_ready,
    output logic commit_valid,
    output arch_width_t imem_addr,
    output arch_width_t commit_pc,
    output arch_width_t commit_next_pc,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx
);

logic rsp_accept;
logic pc_we;
logic bubble_dec;
logic exe_advance;
pc_sel_t pc_sel;
logic dec_valid;
logic branch_in_dec;
logic jump_in_dec;
arch_width_t pc_dec;
arch_width_t dec_imm;
arch_width_t fetch_pc;
inst_t dec_inst;
inst_class_t dec_class;
pc_sel_t dec_pc_sel;
logic exe_valid;
logic flow_in_exe;
arch_width_t pc_exe;
arch_width_t exe_target;

assign rsp_accept = imem_rsp_valid && imem_rsp_ready;

fe_ctrl fe_ctrl_i (
    .clk(clk),
    .rst(rst),
    .imem_req_ready(imem_req_ready),
    .imem_rsp_valid(imem_rsp_valid),
    .be_stall(be_stall),
    .branch_in_dec(branch_in_dec),
    .jump_in_dec(jump_in_dec),
    .dec_valid(dec_valid),
    .exe_valid(exe_valid),
    .flow_in_exe(flow_in_exe),
    .pc_dec(pc_dec),
    .pc_exe(pc_exe),
    .dec_pc_sel(dec_pc_sel),
    .imem_req_valid(imem_req_valid),
    .imem_rsp_ready(imem_rsp_ready),
    .pc_we(pc_we),
    .bubble_dec(bubble_dec),
    .exe_advance(exe_advance),
    .pc_sel(pc_sel)
);

// decode freezes while the back end is stalled
fe_decode fe_decode_i (
    .clk(clk),
    .rst(rst),
    .rsp_accept(rsp_accept),
    .bubble_dec(bubble_dec),
    .hold(be_stall),
    .imem_rsp_inst(imem_rsp_inst),
    .fetch_pc(fetch_pc),
    .dec_valid(dec_valid),
    .branch_in_dec(branch_in_dec),
    .jump_in_dec(jump_in_dec),
    .pc_dec(pc_dec),
    .dec_inst(dec_inst),
    .dec_class(dec_class),
    .dec_imm(dec_imm),
    .dec_pc_sel(dec_pc_sel)
);

fe_execute fe_execute_i (
    .clk(clk),
    .rst(rst),
    .exe_advance(exe_advance),
    .dec_valid(dec_valid),
    .pc_dec(pc_dec),
    .dec_imm(dec_imm),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .dec_inst(dec_inst),
    .dec_class(dec_class),
    .exe_valid(exe_valid),
    .flow_in_exe(flow_in_exe),
    .pc_exe(pc_exe),
    .exe_target(exe_target),
    .rs1_idx(rs1_idx),
    .rs2_idx(rs2_idx)
);

fe_result #(
    .reset_pc(reset_pc)
) fe_result_i (
    .clk(clk),
    .rst(rst),
    .pc_we(pc_we),
    .exe_valid(exe_valid),
    .exe_advance(exe_advance),
    .flow_in_exe(flow_in_exe),
    .pc_sel(pc_sel),
    .exe_target(exe_target),
    .pc_exe(pc_exe),
    .imem_addr(imem_addr),
    .fetch_pc(fetch_pc),
    .commit_valid(commit_valid),
    .commit_pc(commit_pc),
    .commit_next_pc(commit_next_pc)
);

endmodule

/* sim/fe_imem_model.sv */
module fe_imem_model
    import fe_arch_pkg::*;
#(
    parameter arch_width_t base = RESET_PC,
    parameter int words = 18,
    parameter int seed_init = 32'hddeaa294
) (
    input  logic clk,
    input  logic rst,
    input  logic req_valid,
    input  arch_width_t addr,
    input  logic rsp_ready,
    output logic req_ready,
    output logic rsp_valid,
    output inst_t rsp_inst
);

localparam opcode_t OPC_OP_IMM = 7'b001_0011;

inst_t prog [words];
integer seed;
int wait_cnt;
logic busy;
arch_width_t req_addr;

function automatic inst_t enc_b(input logic [2:0] funct3, input reg_idx_t rs1,
                                input reg_idx_t rs2, input logic [12:0] imm);
    enc_b = {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic inst_t enc_j(input reg_idx_t rd, input logic [20:0] imm);
    enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

function automatic inst_t enc_i(input opcode_t opcode, input reg_idx_t rd,
                                input reg_idx_t rs1, input logic [11:0] imm);
    enc_i = {imm, rs1, 3'b000, rd, opcode};
endfunction

// outside the program every word is an op-imm built from the whole address
function automatic inst_t word_at(input arch_width_t a);
    arch_width_t off;
    arch_width_t mix;
    off = a - base;
    mix = a ^ {a[15:0], a[31:16]};
    if (off < words * 4) begin
        word_at = prog[off[31:2]];
    end else begin
        word_at = {mix[31:7], OPC_OP_IMM};
    end
endfunction

// loop of eleven retired instructions, skipped slots hold distinct addi words
initial begin
    prog[0] = enc_i(OPC_OP_IMM, 5'd6, 5'd0, 12'd1);
    prog[1] = enc_b(3'b000, 5'd1, 5'd2, 13'd8);
    prog[2] = enc_i(OPC_OP_IMM, 5'd7, 5'd0, 12'd2);
    prog[3] = enc_b(3'b001, 5'd1, 5'd2, 13'd16);
    prog[4] = enc_b(3'b100, 5'd3, 5'd4, 13'd8);
    prog[5] = enc_i(OPC_OP_IMM, 5'd7, 5'd0, 12'd5);
    prog[6] = enc_b(3'b110, 5'd3, 5'd4, 13'd12);
    prog[7] = enc_j(5'd1, 21'd8);
    prog[8] = enc_i(OPC_OP_IMM, 5'd7, 5'd0, 12'd8);
    // odd offset, target bit 0 must be dropped
    prog[9] = enc_i(OPC_JALR, 5'd0, 5'd5, 12'd5);
    prog[10] = enc_i(OPC_OP_IMM, 5'd7, 5'd0, 12'd10);
    prog[11] = enc_i(OPC_OP_IMM, 5'd7, 5'd0, 12'd11);
    prog[12] = enc_i(OPC_OP_IMM, 5'd7, 5'd0, 12'd12);
    prog[13] = enc_b(3'b101, 5'd4, 5'd3, 13'd8);
    prog[14] = enc_i(OPC_OP_IMM, 5'd7, 5'd0, 12'd14);
    prog[15] = enc_i(OPC_OP_IMM, 5'd8, 5'd0, 12'd15);
    prog[16] = enc_b(3'b111, 5'd4, 5'd3, 13'd8);
    prog[17] = enc_j(5'd0, -21'd68);
end

// one request at a time, answered after 1 to 4 cycles
initial begin
    seed = seed_init;
    busy = 1'b0;
    wait_cnt = 0;
    req_addr = '0;
    req_ready = 1'b0;
    rsp_valid = 1'b0;
    rsp_inst = '0;
    forever begin
        @(posedge clk);
        if (rst) begin
            busy <= 1'b0;
            req_ready <= 1'b0;
            rsp_valid <= 1'b0;
        end else if (!busy) begin
            if (req_valid && req_ready) begin
                busy <= 1'b1;
                req_ready <= 1'b0;
                req_addr <= addr;
                wait_cnt <= 1 + {$random(seed)} % 4;
            end else begin
                req_ready <= 1'b1;
            end
        end else if (rsp_valid) begin
            if (rsp_ready) begin
                rsp_valid <= 1'b0;
                busy <= 1'b0;
                req_ready <= 1'b1;
            end
        end else if (wait_cnt > 1) begin
            wait_cnt <= wait_cnt - 1;
        end else begin
            rsp_valid <= 1'b1;
            rsp_inst <= word_at(req_addr);
        end
    end
end

endmodule

/* sim/fe_tb.sv */
module fe_tb
    import fe_arch_pkg::*;
();

localparam arch_width_t BOOT_PC = 32'h0000_2000;
localparam int SEED = 32'hddeaa294;
localparam int PROG_WORDS = 18;
localparam int NUM_RETIRE = 44;
localparam int RESET_CYCLES = 10;
localparam int WAIT_LIMIT = 200;

logic clk = 1'b0;
logic rst;
logic be_stall;
logic imem_req_ready;
logic imem_rsp_valid;
inst_t imem_rsp_inst;
arch_width_t rs1_data;
arch_width_t rs2_data;
logic imem_req_valid;
logic imem_rsp_ready;
logic commit_valid;
arch_width_t imem_addr;
arch_width_t commit_pc;
arch_width_t commit_next_pc;
reg_idx_t rs1_idx;
reg_idx_t rs2_idx;

integer seed;
int stall_left;
int errors = 0;
int timeouts = 0;
int retired = 0;
int redirects = 0;
int stall_cycles = 0;
int requests = 0;
int responses = 0;
logic rst_prev = 1'b1;
logic stall_prev = 1'b0;
logic outstanding = 1'b0;
logic first_req_seen = 1'b0;
arch_width_t expected_pc = BOOT_PC;
// without speculation every fetch retires, so fetches follow the same walk
arch_width_t expected_fetch = BOOT_PC;
inst_t word;
arch_width_t next_pc;

fe_top #(
    .reset_pc(BOOT_PC)
) fe_top_i (
    .clk(clk),
    .rst(rst),
    .imem_req_ready(imem_req_ready),
    .imem_rsp_valid(imem_rsp_valid),
    .be_stall(be_stall),
    .imem_rsp_inst(imem_rsp_inst),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .imem_req_valid(imem_req_valid),
    .imem_rsp_ready(imem_rsp_ready),
    .commit_valid(commit_valid),
    .imem_addr(imem_addr),
    .commit_pc(commit_pc),
    .commit_next_pc(commit_next_pc),
    .rs1_idx(rs1_idx),
    .rs2_idx(rs2_idx)
);

fe_imem_model #(
    .base(BOOT_PC),
    .words(PROG_WORDS),
    .seed_init(SEED)
) imem_i (
    .clk(clk),
    .rst(rst),
    .req_valid(imem_req_valid),
    .addr(imem_addr),
    .rsp_ready(imem_rsp_ready),
    .req_ready(imem_req_ready),
    .rsp_valid(imem_rsp_valid),
    .rsp_inst(imem_rsp_inst)
);

// fixed register file contents
// x5 points into the program for jalr
function automatic arch_width_t reg_value(input reg_idx_t idx);
    if ($isunknown(idx)) begin
        reg_value = '0;
    end else begin
        case (idx)
            5'd0: reg_value = '0;
            5'd1: reg_value = 32'd5;
            5'd2: reg_value = 32'd5;
            5'd3: reg_value = 32'hffff_fffd;
            5'd4: reg_value = 32'd7;
            5'd5: reg_value = BOOT_PC + 32'h30;
            default: reg_value = {4{3'b101, idx}};
        endcase
    end
endfunction

function automatic inst_t program_word(input arch_width_t pc);
    arch_width_t off;
    off = pc - BOOT_PC;
    if (off < PROG_WORDS * 4) begin
        program_word = imem_i.prog[off[31:2]];
    end else begin
        program_word = 32'h0000_0013;
    end
endfunction

// next pc of one instruction by the rv32i rules
function automatic arch_width_t ref_next_pc(input arch_width_t pc, input inst_t w);
    arch_width_t op_a;
    arch_width_t op_b;
    arch_width_t imm_b;
    arch_width_t imm_j;
    arch_width_t imm_i;
    arch_width_t target;
    logic taken;
    op_a = reg_value(w[19:15]);
    op_b = reg_value(w[24:20]);
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    imm_i = {{20{w[31]}}, w[31:20]};
    case (w[14:12])
        3'b000: taken = (op_a == op_b);
        3'b001: taken = (op_a != op_b);
        3'b100: taken = ($signed(op_a) < $signed(op_b));
        3'b101: taken = ($signed(op_a) >= $signed(op_b));
        3'b110: taken = (op_a < op_b);
        3'b111: taken = (op_a >= op_b);
        default: taken = 1'b0;
    endcase
    case (w[6:0])
        7'b110_0011: ref_next_pc = taken ? pc + imm_b : pc + 32'd4;
        7'b110_1111: ref_next_pc = pc + imm_j;
        7'b110_0111: begin
            target = op_a + imm_i;
            ref_next_pc = {target[31:1], 1'b0};
        end
        default: ref_next_pc = pc + 32'd4;
    endcase
endfunction

task automatic report_error(input string msg);
    errors++;
    $display("FAIL %0t: %s", $time, msg);
endtask

// combinational register file read
assign rs1_data = reg_value(rs1_idx);
assign rs2_data = reg_value(rs2_idx);

initial begin
    forever #20 clk = ~clk;
end

// random back-end stall bursts of 1 to 5 cycles
initial begin
    seed = SEED;
    stall_left = 0;
    be_stall = 1'b0;
    forever begin
        @(posedge clk);
        if (rst) begin
            be_stall <= 1'b0;
        end else if (stall_left > 0) begin
            be_stall <= 1'b1;
            stall_left--;
        end else begin
            be_stall <= 1'b0;
            if ({$random(seed)} % 6 == 0) begin
                stall_left = 1 + {$random(seed)} % 5;
            end
        end
    end
end

// inputs only move at rising edges, so the falling edge sees settled values
always @(negedge clk) begin
    if (rst || rst_prev) begin
        assert (!imem_req_valid && !commit_valid)
            else report_error("request or retire during reset");
    end
    if (be_stall) begin
        assert (!imem_req_valid) else report_error("fetch request during back-end stall");
        stall_cycles++;
    end
    if (stall_prev) begin
        assert (!commit_valid) else report_error("retire during back-end stall");
    end
    assert (!(imem_req_valid && outstanding))
        else report_error("second request while one is outstanding");
    if (imem_rsp_valid && imem_rsp_ready) begin
        assert (outstanding) else report_error("response accepted without a request");
        outstanding = 1'b0;
        responses++;
    end
    if (imem_req_valid && imem_req_ready) begin
        assert (imem_addr == expected_fetch)
            else report_error($sformatf("fetch at %h, expected %h", imem_addr, expected_fetch));
        expected_fetch = ref_next_pc(expected_fetch, program_word(expected_fetch));
        first_req_seen = 1'b1;
        outstanding = 1'b1;
        requests++;
    end
    if (commit_valid) begin
        word = program_word(expected_pc);
        next_pc = ref_next_pc(expected_pc, word);
        assert (commit_pc == expected_pc)
            else report_error($sformatf("commit pc %h, expected %h", commit_pc, expected_pc));
        assert (commit_next_pc == next_pc)
            else report_error($sformatf("next pc %h after %h, expected %h",
                                        commit_next_pc, expected_pc, next_pc));
        if (next_pc != expected_pc + 32'd4) begin
            redirects++;
        end
        expected_pc = next_pc;
        retired++;
    end
    rst_prev = rst;
    stall_prev = be_stall;
end

initial begin : run_test
    int cycles;
    int n;
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    cycles = 0;
    while (!first_req_seen && cycles < WAIT_LIMIT) begin
        @(posedge clk);
        cycles++;
    end
    if (!first_req_seen) begin
        $display("timeout: no fetch request accepted after reset");
        timeouts++;
    end
    n = 0;
    while (timeouts == 0 && n < NUM_RETIRE) begin
        cycles = 0;
        while (retired <= n && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (retired <= n) begin
            $display("timeout: instruction %0d did not retire within %0d cycles", n, WAIT_LIMIT);
            timeouts++;
        end
        n++;
    end
    assert (responses == requests || responses + 1 == requests)
        else report_error($sformatf("%0d requests but %0d responses", requests, responses));
    $display("retired %0d, redirects %0d, stall cycles %0d, requests %0d, responses %0d, %s",
             retired, redirects, stall_cycles, requests, responses,
             $sformatf("errors %0d, timeouts %0d", errors, timeouts));
    if (errors == 0 && timeouts == 0) begin
        $display("TEST OK");
    end else begin
        $display("TEST FAILED");
    end
    $finish;
end

endmodule

/* sim.f */
verilog/fe_arch_pkg.sv
verilog/fe_ctrl_pkg.sv
verilog/fe_decode.sv
verilog/fe_ctrl.sv
verilog/fe_execute.sv
verilog/fe_result.sv
verilog/fe_top.sv
sim/fe_imem_model.sv
sim/fe_tb.sv

/* Bender.yml */
package:
  name: fe_frontend

sources:
  - verilog/fe_arch_pkg.sv
  - verilog/fe_ctrl_pkg.sv
  - verilog/fe_decode.sv
  - verilog/fe_ctrl.sv
  - verilog/fe_execute.sv
  - verilog/fe_result.sv
  - verilog/fe_top.sv
  - target: simulation
    files:
      - sim/fe_imem_model.sv
      - sim/fe_tb.sv
